// ==== lockstep.f ====
+incdir+source
source/lockstep_pkg.sv
source/lockstep_rst_seq.sv
source/lockstep_in_delay.sv
source/mini_core.sv
source/lockstep_cmp.sv
source/lockstep_top.sv
test/lockstep_checker.sv
test/tb_lockstep.sv

// ==== Makefile ====
# Verilator build and run of the lockstep checker testbench.
# Any variable below can be set on the command line, e.g. make test TOP=...

VERILATOR ?= verilator
TOP       ?= tb_lockstep
FILELIST  ?= lockstep.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --timescale 1ns/100ps -j 0
PASS_MSG  ?= TB PASSED

.DEFAULT_GOAL := help
.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run the testbench, fails unless it passes"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS PASS_MSG"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$($(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// ==== test/tb_lockstep.sv ====
////////////////////
// Testbench of the lockstep checker. Plays the main core from a table of
// rows, drives its inputs and outputs into the DUT, and has the checker
// judge alert_o.
////////////////////
`include "lockstep_config.svh"

module tb_lockstep;

  timeunit 1ns;
  timeprecision 100ps;

  import lockstep_pkg::*;

  localparam int NUM_ROWS    = 42;
  localparam int CLK_HALF_NS = 50;
  localparam int RST_CYCLES  = 16;
  localparam int WATCHDOG_NS = (NUM_ROWS + RST_CYCLES + `LS_OFFSET + 10) * 2 * CLK_HALF_NS;

  // One stimulus row, with rnd set rd and the operands come from the LCG
  typedef struct packed {
    logic                 valid;
    logic [`LS_OP_W-1:0]  op;
    logic [`LS_REG_W-1:0] rd;
    logic [`LS_REG_W-1:0] rs1;
    logic [`LS_REG_W-1:0] rs2;
    logic [`LS_IMM_W-1:0] imm;
    logic                 rnd;
    core_out_t            mask;
  } row_t;

  // Mask bits: wb_valid 19, wb_addr 18:17, wb_data 16:1, illegal 0
  localparam row_t ROWS [NUM_ROWS] = '{
    // valid, opcode, rd, rs1, rs2, imm, rnd, mask
    // Idle after reset
    '{1'b0, 4'h0, 2'd0, 2'd0, 2'd0, 10'd0, 1'b0, 20'h00000},
    '{1'b0, 4'h0, 2'd0, 2'd0, 2'd0, 10'd0, 1'b0, 20'h00000},
    '{1'b0, 4'h0, 2'd0, 2'd0, 2'd0, 10'd0, 1'b0, 20'h00000},
    '{1'b0, 4'h0, 2'd0, 2'd0, 2'd0, 10'd0, 1'b0, 20'h00000},
    '{1'b0, 4'h0, 2'd0, 2'd0, 2'd0, 10'd0, 1'b0, 20'h00000},
    '{1'b0, 4'h0, 2'd0, 2'd0, 2'd0, 10'd0, 1'b0, 20'h00000},
    // Clean directed sequence
    '{1'b1, `LS_OP_LDI,  2'd0, 2'd0, 2'd0, 10'd100,  1'b0, 20'h00000},
    '{1'b1, `LS_OP_LDI,  2'd1, 2'd0, 2'd0, 10'd37,   1'b0, 20'h00000},
    '{1'b1, `LS_OP_LDI,  2'd2, 2'd0, 2'd0, 10'd1023, 1'b0, 20'h00000},
    '{1'b1, `LS_OP_LDI,  2'd3, 2'd0, 2'd0, 10'd5,    1'b0, 20'h00000},
    '{1'b1, `LS_OP_ADD,  2'd0, 2'd0, 2'd1, 10'd0,    1'b0, 20'h00000},
    '{1'b1, `LS_OP_SUB,  2'd1, 2'd2, 2'd3, 10'd0,    1'b0, 20'h00000},
    '{1'b1, `LS_OP_XOR,  2'd2, 2'd0, 2'd1, 10'd0,    1'b0, 20'h00000},
    '{1'b1, `LS_OP_AND,  2'd3, 2'd2, 2'd0, 10'd0,    1'b0, 20'h00000},
    '{1'b1, `LS_OP_ADDI, 2'd3, 2'd0, 2'd0, 10'd200,  1'b0, 20'h00000},
    '{1'b1, `LS_OP_SUB,  2'd0, 2'd3, 2'd2, 10'd0,    1'b0, 20'h00000},
    // Clean random operands
    '{1'b1, `LS_OP_ADD,  2'd0, 2'd0, 2'd0, 10'd0, 1'b1, 20'h00000},
    '{1'b1, `LS_OP_LDI,  2'd0, 2'd0, 2'd0, 10'd0, 1'b1, 20'h00000},
    '{1'b1, `LS_OP_XOR,  2'd0, 2'd0, 2'd0, 10'd0, 1'b1, 20'h00000},
    '{1'b1, `LS_OP_ADDI, 2'd0, 2'd0, 2'd0, 10'd0, 1'b1, 20'h00000},
    '{1'b1, `LS_OP_SUB,  2'd0, 2'd0, 2'd0, 10'd0, 1'b1, 20'h00000},
    '{1'b1, `LS_OP_AND,  2'd0, 2'd0, 2'd0, 10'd0, 1'b1, 20'h00000},
    '{1'b1, `LS_OP_LDI,  2'd0, 2'd0, 2'd0, 10'd0, 1'b1, 20'h00000},
    '{1'b1, `LS_OP_ADDI, 2'd0, 2'd0, 2'd0, 10'd0, 1'b1, 20'h00000},
    '{1'b0, 4'h0,        2'd0, 2'd0, 2'd0, 10'd0, 1'b0, 20'h00000},
    // Single-bit corruption of wb_data, wb_addr and wb_valid
    '{1'b1, `LS_OP_ADD,  2'd1, 2'd0, 2'd3, 10'd0,  1'b0, 20'h00002},
    '{1'b0, 4'h0,        2'd0, 2'd0, 2'd0, 10'd0,  1'b0, 20'h00000},
    '{1'b1, `LS_OP_LDI,  2'd2, 2'd0, 2'd0, 10'd77, 1'b0, 20'h20000},
    '{1'b0, 4'h0,        2'd0, 2'd0, 2'd0, 10'd0,  1'b0, 20'h00000},
    '{1'b0, 4'h0,        2'd0, 2'd0, 2'd0, 10'd0,  1'b0, 20'h80000},
    '{1'b0, 4'h0,        2'd0, 2'd0, 2'd0, 10'd0,  1'b0, 20'h00000},
    '{1'b1, `LS_OP_XOR,  2'd0, 2'd0, 2'd0, 10'd0,  1'b1, 20'h10000},
    // Illegal opcodes, the last one with its illegal bit flipped
    '{1'b1, 4'hf, 2'd1, 2'd2, 2'd3, 10'd0, 1'b0, 20'h00000},
    '{1'b1, 4'h0, 2'd2, 2'd0, 2'd1, 10'd0, 1'b0, 20'h00000},
    '{1'b1, 4'h7, 2'd3, 2'd1, 2'd0, 10'd0, 1'b0, 20'h00001},
    '{1'b0, 4'h0, 2'd0, 2'd0, 2'd0, 10'd0, 1'b0, 20'h00000},
    // Back-to-back corruption
    '{1'b1, `LS_OP_ADD,  2'd0, 2'd1, 2'd2, 10'd0, 1'b0, 20'h00002},
    '{1'b1, `LS_OP_SUB,  2'd3, 2'd0, 2'd1, 10'd0, 1'b0, 20'h00004},
    '{1'b1, `LS_OP_ADDI, 2'd3, 2'd0, 2'd0, 10'd9, 1'b0, 20'h40000},
    '{1'b1, `LS_OP_LDI,  2'd1, 2'd0, 2'd0, 10'd3, 1'b0, 20'h00000},
    '{1'b0, 4'h0,        2'd0, 2'd0, 2'd0, 10'd0, 1'b0, 20'h00000},
    '{1'b0, 4'h0,        2'd0, 2'd0, 2'd0, 10'd0, 1'b0, 20'h00000}
  };

  logic      clk_i;
  logic      rst_ni;
  core_in_t  core_in;
  core_out_t core_out;
  logic      alert;

  // Mask of the row at the DUT input, and the one applied to core_out
  core_out_t row_mask;
  core_out_t corrupt_mask;

  // Register file of the main core model
  logic [`LS_DATA_W-1:0] model_regs [`LS_NUM_REGS];

  int exp_alerts = 0;
  int exp_wbs    = 0;
  int tb_errs    = 0;
  int chk_checks;
  int chk_errs;
  int chk_alerts;
  int chk_wbs;

  initial clk_i = 1'b0;
  always #(CLK_HALF_NS) clk_i = ~clk_i;

  lockstep_top i_dut (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .core_in_i (core_in),
    .core_out_i(core_out),
    .alert_o   (alert)
  );

  lockstep_checker u_checker (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .core_out_i    (core_out),
    .corrupt_mask_i(corrupt_mask),
    .alert_i       (alert),
    .check_cnt_o   (chk_checks),
    .err_cnt_o     (chk_errs),
    .alert_cnt_o   (chk_alerts),
    .wb_cnt_o      (chk_wbs)
  );

  ////////////////////
  // Helpers
  ////////////////////

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // Only a valid row with one of the six defined opcodes writes a register
  function automatic logic writes_back(input row_t row);
    logic legal;
    legal = (row.op == `LS_OP_ADD) || (row.op == `LS_OP_SUB) ||
            (row.op == `LS_OP_XOR) || (row.op == `LS_OP_AND) ||
            (row.op == `LS_OP_LDI) || (row.op == `LS_OP_ADDI);
    return row.valid && legal;
  endfunction

  // Packs a row into the instruction word, immediate forms use the i view
  function automatic core_in_t build_in(input row_t row, input logic [31:0] rnd);
    core_in_t ci;
    ci = '0;
    ci.instr_valid = row.valid;
    if (row.op == `LS_OP_LDI || row.op == `LS_OP_ADDI) begin
      ci.instr.i.opcode = row.op;
      ci.instr.i.rd     = row.rnd ? rnd[31:30] : row.rd;
      ci.instr.i.imm    = row.rnd ? rnd[29:20] : row.imm;
    end else begin
      ci.instr.r.opcode = row.op;
      ci.instr.r.rd     = row.rnd ? rnd[31:30] : row.rd;
      ci.instr.r.rs1    = row.rnd ? rnd[29:28] : row.rs1;
      ci.instr.r.rs2    = row.rnd ? rnd[27:26] : row.rs2;
    end
    return ci;
  endfunction

  // Main core model, the result appears one edge after the instruction
  task automatic exec_main_core(input core_in_t ci, output core_out_t res);
    logic [`LS_DATA_W-1:0] a;
    logic [`LS_DATA_W-1:0] b;
    logic [`LS_DATA_W-1:0] imm;
    res = '0;
    if (ci.instr_valid) begin
      a   = model_regs[ci.instr.r.rs1];
      b   = model_regs[ci.instr.r.rs2];
      imm = {{(`LS_DATA_W - `LS_IMM_W){1'b0}}, ci.instr.i.imm};
      res.wb_valid = 1'b1;
      res.wb_addr  = ci.instr.i.rd;
      case (ci.instr.i.opcode)
        `LS_OP_ADD:  res.wb_data = a + b;
        `LS_OP_SUB:  res.wb_data = a - b;
        `LS_OP_XOR:  res.wb_data = a ^ b;
        `LS_OP_AND:  res.wb_data = a & b;
        `LS_OP_LDI:  res.wb_data = imm;
        `LS_OP_ADDI: res.wb_data = model_regs[ci.instr.i.rd] + imm;
        default: begin
          res         = '0;
          res.illegal = 1'b1;
        end
      endcase
      if (res.wb_valid) begin
        model_regs[res.wb_addr] = res.wb_data;
      end
    end
  endtask

  // One rising edge: answer the row now at the inputs, then present the next
  task automatic step(input core_in_t nxt_in, input core_out_t nxt_mask);
    core_out_t res;
    @(posedge clk_i);
    exec_main_core(core_in, res);
    core_out     <= res ^ row_mask;
    corrupt_mask <= row_mask;
    core_in      <= nxt_in;
    row_mask     <= nxt_mask;
  endtask

  ////////////////////
  // Stimulus
  ////////////////////

  initial begin
    logic [31:0] seed;
    seed = 32'h8bfdbf5e;
    rst_ni       <= 1'b0;
    core_in      <= '0;
    core_out     <= '0;
    row_mask     <= '0;
    corrupt_mask <= '0;
    for (int n = 0; n < `LS_NUM_REGS; n++) begin
      model_regs[n] = '0;
    end
    repeat (RST_CYCLES) @(posedge clk_i);
    rst_ni <= 1'b1;

    for (int n = 0; n < NUM_ROWS; n++) begin
      if (ROWS[n].rnd) begin
        seed = lcg_next(seed);
      end
      if (ROWS[n].mask != '0) begin
        exp_alerts++;
      end
      // A flipped wb_valid bit adds or removes one writeback pulse
      if (writes_back(ROWS[n]) ^ ROWS[n].mask.wb_valid) begin
        exp_wbs++;
      end
      step(build_in(ROWS[n], seed), ROWS[n].mask);
    end
    // Let the last samples drain through both delay lines
    repeat (`LS_OFFSET + 3) step('0, '0);
    @(posedge clk_i);

    if (chk_alerts != exp_alerts) begin
      $display("Saw %0d alert cycles but %0d rows were corrupted", chk_alerts, exp_alerts);
      tb_errs++;
    end
    if (chk_wbs != exp_wbs) begin
      $display("Saw %0d writebacks on core_out but the table gives %0d", chk_wbs, exp_wbs);
      tb_errs++;
    end
    $display("Checks %0d, checker errors %0d, testbench errors %0d, writebacks %0d",
             chk_checks, chk_errs, tb_errs, chk_wbs);
    if (chk_errs == 0 && tb_errs == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #(WATCHDOG_NS);
    $display("Timeout, the run did not finish within %0d ns", WATCHDOG_NS);
    $display("TB FAILED");
    $finish;
  end

endmodule

// ==== test/lockstep_checker.sv ====
////////////////////
// Checker of the lockstep testbench. Predicts alert_o from the corrupt
// mask that the main core model applied, compares and counts errors.
////////////////////
`include "lockstep_config.svh"

module lockstep_checker (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  lockstep_pkg::core_out_t core_out_i,
  input  lockstep_pkg::core_out_t corrupt_mask_i,
  input  logic                    alert_i,
  output int                      check_cnt_o,
  output int                      err_cnt_o,
  output int                      alert_cnt_o,
  output int                      wb_cnt_o
);

  timeunit 1ns;
  timeprecision 100ps;

  import lockstep_pkg::*;

  // History of nonzero masks, bit 0 is the newest sample
  logic [`LS_OFFSET+1:0] mask_hist;
  logic                  exp_alert;
  core_out_t             out_seen;

  int check_cnt = 0;
  int err_cnt   = 0;
  int alert_cnt = 0;
  int wb_cnt    = 0;

  ////////////////////
  // Prediction
  ////////////////////

  // Falling edge, the DUT ports have settled by then
  always @(negedge clk_i) begin
    out_seen = core_out_i;
    if (!rst_ni) begin
      mask_hist = '0;
    end else begin
      mask_hist = {mask_hist[`LS_OFFSET:0], (corrupt_mask_i != '0)};
    end
    // A corrupted sample surfaces LS_OFFSET+1 cycles after it was driven
    exp_alert = mask_hist[`LS_OFFSET+1];

    ////////////////////
    // Compare
    ////////////////////

    check_cnt++;
    if ($isunknown(alert_i)) begin
      $display("alert_o is unknown at %0t ns", $time);
      err_cnt++;
    end else if (alert_i !== exp_alert) begin
      $display("Fail alert_o expected %h actual %h at %0t ns", exp_alert, alert_i, $time);
      err_cnt++;
    end

    if (alert_i === 1'b1) begin
      alert_cnt++;
    end

    // Writeback pulses the main core delivered
    if (out_seen.wb_valid === 1'b1) begin
      wb_cnt++;
    end
  end

  assign check_cnt_o = check_cnt;
  assign err_cnt_o   = err_cnt;
  assign alert_cnt_o = alert_cnt;
  assign wb_cnt_o    = wb_cnt;

endmodule

// ==== source/lockstep_top.sv ====
////////////////////
// Lockstep checker top. Runs a delayed shadow mini_core on the main core
// inputs and raises alert_o when the outputs of the two cores differ.
////////////////////

module lockstep_top (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  lockstep_pkg::core_in_t  core_in_i,
  input  lockstep_pkg::core_out_t core_out_i,
  output logic                    alert_o
);

  import lockstep_pkg::*;

  logic      rst_shadow_n;
  logic      cmp_en;
  core_in_t  shadow_in;
  core_out_t shadow_out;

  ////////////////////
  // Input side
  ////////////////////

  lockstep_rst_seq u_rst_seq (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .rst_shadow_no(rst_shadow_n),
    .cmp_en_o     (cmp_en)
  );

  lockstep_in_delay u_in_delay (
    .clk_i (clk_i),
    .rst_ni(rst_ni),
    .in_i  (core_in_i),
    .in_o  (shadow_in)
  );

  ////////////////////
  // Shadow core
  ////////////////////

  // Runs LS_OFFSET cycles behind the main core, on its own reset
  mini_core u_shadow_core (
    .clk_i (clk_i),
    .rst_ni(rst_shadow_n),
    .in_i  (shadow_in),
    .out_o (shadow_out)
  );

  ////////////////////
  // Output side
  ////////////////////

  lockstep_cmp u_cmp (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .cmp_en_i    (cmp_en),
    .main_out_i  (core_out_i),
    .shadow_out_i(shadow_out),
    .alert_o     (alert_o)
  );

endmodule

// ==== source/lockstep_cmp.sv ====
////////////////////
// Output compare of the lockstep pair. Delays the main core outputs to
// line up with the registered shadow outputs and flags any difference.
////////////////////
`include "lockstep_config.svh"

module lockstep_cmp (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    cmp_en_i,
  input  lockstep_pkg::core_out_t main_out_i,
  input  lockstep_pkg::core_out_t shadow_out_i,
  output logic                    alert_o
);

  import lockstep_pkg::*;

  // One extra stage on the main side matches the shadow output register
  core_out_t [`LS_OFFSET:0] main_q;
  core_out_t                shadow_q;

  ////////////////////
  // Main output delay
  ////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      main_q <= '0;
    end else begin
      for (int n = 0; n < `LS_OFFSET; n++) begin
        main_q[n] <= main_q[n+1];
      end
      main_q[`LS_OFFSET] <= main_out_i;
    end
  end

  ////////////////////
  // Shadow output register
  ////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      shadow_q <= '0;
    end else begin
      shadow_q <= shadow_out_i;
    end
  end

  // Whole-struct compare, any single bit raises the alert
  assign alert_o = cmp_en_i & (main_q[0] != shadow_q);

endmodule

// ==== source/mini_core.sv ====
////////////////////
// Small register-machine core. Executes one instruction per valid strobe
// and registers its writeback, one cycle later. Used as the shadow copy.
////////////////////
`include "lockstep_config.svh"

module mini_core (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  lockstep_pkg::core_in_t  in_i,
  output lockstep_pkg::core_out_t out_o
);

  import lockstep_pkg::*;

  logic [`LS_DATA_W-1:0] regs_q [`LS_NUM_REGS];

  logic [`LS_DATA_W-1:0] rs1_val;
  logic [`LS_DATA_W-1:0] rs2_val;
  logic [`LS_DATA_W-1:0] rd_val;
  logic [`LS_DATA_W-1:0] imm_val;

  core_out_t out_d;
  core_out_t out_q;

  ////////////////////
  // Operand fetch
  ////////////////////

  // Register operands through the r view
  assign rs1_val = regs_q[in_i.instr.r.rs1];
  assign rs2_val = regs_q[in_i.instr.r.rs2];

  // Immediate forms read rd and imm through the i view
  assign rd_val  = regs_q[in_i.instr.i.rd];
  assign imm_val = {{(`LS_DATA_W - `LS_IMM_W){1'b0}}, in_i.instr.i.imm};

  ////////////////////
  // Execute
  ////////////////////

  always_comb begin
    // Quiet outputs when no instruction comes in
    out_d = '0;
    if (in_i.instr_valid) begin
      out_d.wb_valid = 1'b1;
      out_d.wb_addr  = in_i.instr.r.rd;
      case (in_i.instr.r.opcode)
        `LS_OP_ADD:  out_d.wb_data = rs1_val + rs2_val;
        `LS_OP_SUB:  out_d.wb_data = rs1_val - rs2_val;
        `LS_OP_XOR:  out_d.wb_data = rs1_val ^ rs2_val;
        `LS_OP_AND:  out_d.wb_data = rs1_val & rs2_val;
        `LS_OP_LDI:  out_d.wb_data = imm_val;
        `LS_OP_ADDI: out_d.wb_data = rd_val + imm_val;
        default: begin
          // Unknown opcode, no writeback at all
          out_d.wb_valid = 1'b0;
          out_d.wb_addr  = '0;
          out_d.illegal  = 1'b1;
        end
      endcase
    end
  end

  ////////////////////
  // Writeback
  ////////////////////

  // Register file and output register update on the same edge
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int n = 0; n < `LS_NUM_REGS; n++) begin
        regs_q[n] <= '0;
      end
      out_q <= '0;
    end else begin
      if (out_d.wb_valid) begin
        regs_q[out_d.wb_addr] <= out_d.wb_data;
      end
      out_q <= out_d;
    end
  end

  assign out_o = out_q;

endmodule

// ==== source/lockstep_in_delay.sv ====
////////////////////
// Input delay line. The shadow core sees the main core inputs
// LS_OFFSET cycles late.
////////////////////
`include "lockstep_config.svh"

module lockstep_in_delay (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  lockstep_pkg::core_in_t in_i,
  output lockstep_pkg::core_in_t in_o
);

  import lockstep_pkg::*;

  // Entry LS_OFFSET-1 takes the new input, entry 0 feeds the shadow
  core_in_t [`LS_OFFSET-1:0] pipe_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pipe_q <= '0;
    end else begin
      for (int n = 0; n < `LS_OFFSET - 1; n++) begin
        pipe_q[n] <= pipe_q[n+1];
      end
      pipe_q[`LS_OFFSET-1] <= in_i;
    end
  end

  assign in_o = pipe_q[0];

endmodule

// ==== source/lockstep_rst_seq.sv ====
////////////////////
// Reset sequencer of the shadow core. Holds the shadow in reset for
// LS_OFFSET cycles after the system reset, then enables the compare.
////////////////////
`include "lockstep_config.svh"

module lockstep_rst_seq (
  input  logic clk_i,
  input  logic rst_ni,
  output logic rst_shadow_no,
  output logic cmp_en_o
);

  typedef logic [$clog2(`LS_OFFSET)-1:0] cnt_t;

  cnt_t cnt_q;
  logic cnt_done;
  logic rst_shadow_set_q;
  logic cmp_en_q;

  // Terminal count, the counter parks here
  assign cnt_done = (cnt_q == cnt_t'(`LS_OFFSET - 1));

  // System reset pulls the shadow reset and the enable low at once.
  // The release of the shadow reset is synchronous to clk_i
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q            <= '0;
      rst_shadow_set_q <= 1'b0;
      cmp_en_q         <= 1'b0;
    end else begin
      if (!cnt_done) begin
        cnt_q <= cnt_q + 1'b1;
      end
      rst_shadow_set_q <= cnt_done;
      // Compare starts one cycle after the shadow leaves reset
      cmp_en_q         <= rst_shadow_set_q;
    end
  end

  assign rst_shadow_no = rst_shadow_set_q;
  assign cmp_en_o      = cmp_en_q;

endmodule

// ==== source/lockstep_pkg.sv ====
////////////////////
// Types shared by the lockstep checker, the mini_core and the testbench.
// Holds the instruction word and the core input and output bundles.
////////////////////
`include "lockstep_config.svh"

package lockstep_pkg;

  // Register-register view of an instruction
  typedef struct packed {
    logic [`LS_OP_W-1:0]                  opcode;
    logic [`LS_REG_W-1:0]                 rd;
    logic [`LS_REG_W-1:0]                 rs1;
    logic [`LS_REG_W-1:0]                 rs2;
    logic [`LS_IMM_W-2*`LS_REG_W-1:0]     unused;
  } instr_r_t;

  // Immediate view of an instruction
  typedef struct packed {
    logic [`LS_OP_W-1:0]  opcode;
    logic [`LS_REG_W-1:0] rd;
    logic [`LS_IMM_W-1:0] imm;
  } instr_i_t;

  // One 16-bit word, decoded either way
  typedef union packed {
    instr_r_t r;
    instr_i_t i;
  } instr_u;

  ////////////////////
  // Core bundles
  ////////////////////

  // Everything the core samples, 17 bits
  typedef struct packed {
    logic   instr_valid;
    instr_u instr;
  } core_in_t;

  // Everything the core drives, 20 bits
  typedef struct packed {
    logic                  wb_valid;
    logic [`LS_REG_W-1:0]  wb_addr;
    logic [`LS_DATA_W-1:0] wb_data;
    logic                  illegal;
  } core_out_t;

endpackage

// ==== source/lockstep_config.svh ====
////////////////////
// Build-time settings of the lockstep checker and the mini_core instruction set.
// Included by the package, the RTL and the testbench.
////////////////////
`ifndef LOCKSTEP_CONFIG_SVH
`define LOCKSTEP_CONFIG_SVH

// Lockstep delay in cycles, 2 at the least
`define LS_OFFSET   2

`define LS_DATA_W   16
`define LS_NUM_REGS 4
`define LS_REG_W    2
`define LS_OP_W     4
`define LS_IMM_W    10

// Opcodes, everything else is illegal
`define LS_OP_ADD   4'h1
`define LS_OP_SUB   4'h2
`define LS_OP_XOR   4'h3
`define LS_OP_AND   4'h4
`define LS_OP_LDI   4'h8
`define LS_OP_ADDI  4'h9

`endif
